//--- starforceVideo.f
+incdir+source
+incdir+tb
source/starforcePkg.sv
source/axiLiteRegs.sv
source/pixelTiming.sv
source/planeShifter.sv
source/layerMixer.sv
source/starforceVideo.sv
tb/starforceVideo_tb.sv

//--- tb/axiLiteTasks.svh
// AXI4-Lite master tasks and the value check, included inside the testbench module
`ifndef AXILITETASKS_SVH
`define AXILITETASKS_SVH

   // compare two values, stop on the first mismatch
   task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] time %0d ns  %s  got 0x%0h  expected 0x%0h", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // ==================================================
   // bus master
   // ==================================================

   // called 1 ns after a rising edge, returns the same way
   task automatic axiWrite(input logic [`SV_ADDR_W-1:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
      axiReq.awaddr  = addr;
      axiReq.awvalid = 1'b1;
      axiReq.wdata   = data;
      axiReq.wstrb   = 4'hF;
      axiReq.wvalid  = 1'b1;
      axiReq.bready  = 1'b1;
      @(negedge clk);
      while (!axiRsp.awready)
         @(negedge clk);
      @(posedge clk);
      #1;
      axiReq.awvalid = 1'b0;
      axiReq.wvalid  = 1'b0;
      @(negedge clk);
      while (!axiRsp.bvalid)
         @(negedge clk);
      resp = axiRsp.bresp;
      // B handshake on this edge
      @(posedge clk);
      #1;
      axiReq.bready = 1'b0;
   endtask

   task automatic axiRead(input logic [`SV_ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
      axiReq.araddr  = addr;
      axiReq.arvalid = 1'b1;
      axiReq.rready  = 1'b1;
      @(negedge clk);
      while (!axiRsp.arready)
         @(negedge clk);
      @(posedge clk);
      #1;
      axiReq.arvalid = 1'b0;
      @(negedge clk);
      while (!axiRsp.rvalid)
         @(negedge clk);
      data = axiRsp.rdata;
      resp = axiRsp.rresp;
      @(posedge clk);
      #1;
      axiReq.rready = 1'b0;
   endtask

`endif

//--- tb/starforceVideo_tb.sv
// testbench for the tile video engine, run as the simulation top from the file list
`default_nettype none

`include "starforceVideo_defines.svh"

module starforceVideo_tb;

   timeunit 1ns;
   timeprecision 1ps;

   // reset image, two directed, twenty random, final run
   localparam int NumImages     = 24;
   localparam int TilesPerImage = 5;
   localparam int TileCycles    = `SV_TILE_W * `SV_PIXEL_DIV;
   localparam int AxiOps        = 256;
   localparam int AxiOpCycles   = 8;
   localparam int TimeoutCycles =
      2 * (NumImages * TilesPerImage * TileCycles + AxiOps * AxiOpCycles);

   logic                      clk;
   logic                      CR;
   starforcePkg::axiLiteReq_t axiReq;
   starforcePkg::axiLiteRsp_t axiRsp;
   starforcePkg::videoPixel_t pixel;
   logic                      pixelValid;
   logic                      tileStart;

   // register image the DUT should hold
   starforcePkg::layerRegs_t [`SV_LAYERS-1:0] modelLayers;
   starforcePkg::ctrlRegs_t                   modelCtrl;

   // tile collector state
   starforcePkg::layerRegs_t [`SV_LAYERS-1:0] snapLayers;
   starforcePkg::ctrlRegs_t                   snapCtrl;
   int                                        tilesSinceWrite;
   int                                        pixPos;
   logic                                      checkTile;
   int                                        tilesChecked = 0;
   int                                        cycleCount = 0;

   starforceVideo UUT
   (
      .clk          (clk),
      .CR           (CR),
      .axiReq_i     (axiReq),
      .axiRsp_o     (axiRsp),
      .pixel_o      (pixel),
      .pixelValid_o (pixelValid),
      .tileStart_o  (tileStart)
   );

   `include "axiLiteTasks.svh"

   always #2 clk = ~clk;

   // ==================================================
   // reference model
   // ==================================================

   function automatic logic [`SV_ADDR_W-1:0] planesAddr(input int k);
      return `SV_ADDR_W'(k * `SV_LAYER_STRIDE);
   endfunction

   function automatic logic [`SV_ADDR_W-1:0] bankAddr(input int k);
      return `SV_ADDR_W'(k * `SV_LAYER_STRIDE + 4);
   endfunction

   // front layer is the lowest enabled one with a nonzero value
   function automatic starforcePkg::videoPixel_t expectedPixel(
      input starforcePkg::layerRegs_t [`SV_LAYERS-1:0] layers,
      input starforcePkg::ctrlRegs_t ctrl, input int pos);
      starforcePkg::videoPixel_t px;
      int                        bitIdx;
      logic [2:0]                value;
      logic                      found;

      px.colorIndex = '0;
      px.layerId    = 2'd3;
      found         = 1'b0;
      bitIdx        = ctrl.flip ? pos : `SV_TILE_W - 1 - pos;
      for (int k = 0; k < `SV_LAYERS; k++)
      begin
         value = {layers[k].planes[2][bitIdx], layers[k].planes[1][bitIdx],
                  layers[k].planes[0][bitIdx]};
         if (!found && ctrl.layerEnable[k] && value != 3'b000)
         begin
            px.colorIndex = {layers[k].bank, value};
            px.layerId    = 2'(k);
            found         = 1'b1;
         end
      end
      return px;
   endfunction

   // zero-extended readback of the model
   function automatic logic [31:0] expectedRead(input logic [`SV_ADDR_W-1:0] addr);
      logic [31:0] data;

      data = '0;
      for (int k = 0; k < `SV_LAYERS; k++)
      begin
         if (addr == planesAddr(k))
            data[23:0] = modelLayers[k].planes;
         if (addr == bankAddr(k))
            data[3:0] = modelLayers[k].bank;
      end
      if (addr == `SV_CTRL_ADDR)
      begin
         data[2:0] = modelCtrl.layerEnable;
         data[8]   = modelCtrl.flip;
      end
      return data;
   endfunction

   function automatic logic [31:0] ctrlWord(input starforcePkg::ctrlRegs_t ctrl);
      logic [31:0] data;

      data      = '0;
      data[2:0] = ctrl.layerEnable;
      data[8]   = ctrl.flip;
      return data;
   endfunction

   task automatic applyWrite(input logic [`SV_ADDR_W-1:0] addr, input logic [31:0] data);
      for (int k = 0; k < `SV_LAYERS; k++)
      begin
         if (addr == planesAddr(k))
            modelLayers[k].planes = data[23:0];
         if (addr == bankAddr(k))
            modelLayers[k].bank = data[3:0];
      end
      if (addr == `SV_CTRL_ADDR)
      begin
         modelCtrl.layerEnable = data[2:0];
         modelCtrl.flip        = data[8];
      end
   endtask

   // ==================================================
   // stimulus helpers
   // ==================================================

   task automatic writeReg(input logic [`SV_ADDR_W-1:0] addr, input logic [31:0] data);
      logic [1:0] resp;

      axiWrite(addr, data, resp);
      checkValue("bresp", resp, starforcePkg::RESP_OKAY);
      applyWrite(addr, data);
   endtask

   task automatic readCompare(input logic [`SV_ADDR_W-1:0] addr);
      logic [31:0] data;
      logic [1:0]  resp;

      axiRead(addr, data, resp);
      checkValue("rdata", data, expectedRead(addr));
      checkValue("rresp", resp, starforcePkg::RESP_OKAY);
   endtask

   task automatic compareAllRegs();
      for (int k = 0; k < `SV_LAYERS; k++)
      begin
         readCompare(planesAddr(k));
         readCompare(bankAddr(k));
      end
      readCompare(`SV_CTRL_ADDR);
   endtask

   task automatic loadImage(input starforcePkg::layerRegs_t [`SV_LAYERS-1:0] image,
                            input starforcePkg::ctrlRegs_t imageCtrl);
      for (int k = 0; k < `SV_LAYERS; k++)
      begin
         writeReg(planesAddr(k), 32'(image[k].planes));
         writeReg(bankAddr(k), 32'(image[k].bank));
      end
      writeReg(`SV_CTRL_ADDR, ctrlWord(imageCtrl));
   endtask

   // one extra tile covers a tile of the old image still in flight
   task automatic waitTiles();
      int target;

      target = tilesChecked + 3;
      while (tilesChecked < target)
         @(posedge clk);
      @(posedge clk);
      #1;
   endtask

   task automatic readbackChecks();
      logic [`SV_ADDR_W-1:0] badAddr [6];
      logic [31:0]           data;
      logic [1:0]            resp;

      badAddr = '{8'h08, 8'h0C, 8'h1C, 8'h34, 8'h40, 8'hFC};
      for (int k = 0; k < `SV_LAYERS; k++)
      begin
         writeReg(planesAddr(k), $urandom());
         writeReg(bankAddr(k), $urandom());
      end
      writeReg(`SV_CTRL_ADDR, $urandom());
      compareAllRegs();
      foreach (badAddr[i])
      begin
         axiRead(badAddr[i], data, resp);
         checkValue("rdata", data, 32'h0);
         checkValue("rresp", resp, starforcePkg::RESP_SLVERR);
         axiWrite(badAddr[i], $urandom(), resp);
         checkValue("bresp", resp, starforcePkg::RESP_SLVERR);
      end
      // unmapped writes leave every register alone
      compareAllRegs();
   endtask

   task automatic backPressureChecks();
      logic [1:0]  heldResp;
      logic [31:0] heldData;

      // first write left pending, a second one offered behind it
      axiReq.awaddr  = bankAddr(2);
      axiReq.wdata   = 32'h5;
      axiReq.wstrb   = 4'hF;
      axiReq.awvalid = 1'b1;
      axiReq.wvalid  = 1'b1;
      axiReq.bready  = 1'b0;
      @(negedge clk);
      while (!axiRsp.awready)
         @(negedge clk);
      @(posedge clk);
      #1;
      axiReq.wdata = 32'h9;
      @(negedge clk);
      heldResp = axiRsp.bresp;
      checkValue("bresp", heldResp, starforcePkg::RESP_OKAY);
      repeat (6)
      begin
         checkValue("bvalid", axiRsp.bvalid, 1'b1);
         checkValue("bresp", axiRsp.bresp, heldResp);
         checkValue("awready", axiRsp.awready, 1'b0);
         @(negedge clk);
      end
      applyWrite(bankAddr(2), 32'h5);
      @(posedge clk);
      #1;
      axiReq.bready = 1'b1;
      @(negedge clk);
      while (!axiRsp.awready)
         @(negedge clk);
      checkValue("bvalid", axiRsp.bvalid, 1'b0);
      @(posedge clk);
      #1;
      axiReq.awvalid = 1'b0;
      axiReq.wvalid  = 1'b0;
      @(negedge clk);
      while (!axiRsp.bvalid)
         @(negedge clk);
      checkValue("bresp", axiRsp.bresp, starforcePkg::RESP_OKAY);
      @(posedge clk);
      #1;
      axiReq.bready = 1'b0;
      applyWrite(bankAddr(2), 32'h9);

      // read response held with rready low
      axiReq.araddr  = bankAddr(2);
      axiReq.arvalid = 1'b1;
      axiReq.rready  = 1'b0;
      @(negedge clk);
      while (!axiRsp.arready)
         @(negedge clk);
      @(posedge clk);
      #1;
      axiReq.arvalid = 1'b0;
      @(negedge clk);
      heldData = axiRsp.rdata;
      checkValue("rdata", heldData, expectedRead(bankAddr(2)));
      repeat (6)
      begin
         checkValue("rvalid", axiRsp.rvalid, 1'b1);
         checkValue("rdata", axiRsp.rdata, heldData);
         checkValue("rresp", axiRsp.rresp, starforcePkg::RESP_OKAY);
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      axiReq.rready = 1'b1;
      @(posedge clk);
      #1;
      axiReq.rready = 1'b0;
      @(negedge clk);
      checkValue("rvalid", axiRsp.rvalid, 1'b0);
   endtask

   // ==================================================
   // tile checker
   // ==================================================

   always @(negedge clk)
   begin
      if (!CR)
      begin
         tilesSinceWrite = 0;
         pixPos          = `SV_TILE_W;
         checkTile       = 1'b0;
      end
      else
      begin
         // a write response restarts the settling count
         if (axiRsp.bvalid)
            tilesSinceWrite = 0;
         if (pixelValid && tileStart)
         begin
            tilesSinceWrite++;
            pixPos     = 0;
            checkTile  = (tilesSinceWrite >= 2);
            snapLayers = modelLayers;
            snapCtrl   = modelCtrl;
         end
         if (pixelValid && pixPos < `SV_TILE_W)
         begin
            if (checkTile)
               checkValue($sformatf("pixel_o[%0d]", pixPos), pixel,
                          expectedPixel(snapLayers, snapCtrl, pixPos));
            pixPos++;
            if (pixPos == `SV_TILE_W && checkTile)
               tilesChecked++;
         end
      end
   end

   always @(posedge clk)
   begin
      cycleCount++;
      if (cycleCount >= TimeoutCycles)
      begin
         $display("Timeout: the run did not finish within %0d clock cycles", cycleCount);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   // ==================================================
   // main sequence
   // ==================================================

   initial
   begin
      starforcePkg::layerRegs_t [`SV_LAYERS-1:0] image;
      starforcePkg::ctrlRegs_t                   imageCtrl;

      void'($urandom(32'hd27e));
      clk         = 1'b0;
      CR          = 1'b0;
      axiReq      = '0;
      modelLayers = '0;
      modelCtrl   = '0;
      repeat (10) @(posedge clk);
      #1;
      CR = 1'b1;

      // all layers off, background only
      waitTiles();

      // single layer, left shift then flipped
      image                = '0;
      image[1].planes[0]   = 8'b1000_1101;
      image[1].planes[1]   = 8'b1100_0110;
      image[1].planes[2]   = 8'b0010_0100;
      image[1].bank        = 4'hA;
      imageCtrl.layerEnable = 3'b010;
      imageCtrl.flip        = 1'b0;
      loadImage(image, imageCtrl);
      waitTiles();
      imageCtrl.flip = 1'b1;
      writeReg(`SV_CTRL_ADDR, ctrlWord(imageCtrl));
      waitTiles();

      // sparse planes so back layers show through
      for (int i = 0; i < 20; i++)
      begin
         for (int k = 0; k < `SV_LAYERS; k++)
         begin
            image[k].planes = 24'($urandom() & $urandom());
            image[k].bank   = 4'($urandom());
         end
         imageCtrl.layerEnable = 3'(i);
         imageCtrl.flip        = 1'($urandom());
         loadImage(image, imageCtrl);
         waitTiles();
      end

      readbackChecks();
      backPressureChecks();
      waitTiles();

      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- source/starforceVideo.sv
// top level of the tile video engine, joins the register slave, timing, shifters and mixer
`default_nettype none

`include "starforceVideo_defines.svh"

module starforceVideo
(
   input  wire                             clk,
   input  wire                             CR,
   input  wire  starforcePkg::axiLiteReq_t axiReq_i,
   output starforcePkg::axiLiteRsp_t       axiRsp_o,
   output starforcePkg::videoPixel_t       pixel_o,
   output logic                            pixelValid_o,
   output logic                            tileStart_o
);

   starforcePkg::layerRegs_t  [`SV_LAYERS-1:0] layerRegs;
   starforcePkg::ctrlRegs_t                    ctrl;
   starforcePkg::layerPixel_t [`SV_LAYERS-1:0] layerPixels;
   logic                                       pixelEn;
   logic                                       tileLoad;

   // ==================================================
   // input side
   // ==================================================

   axiLiteRegs regs
   (
      .clk         (clk),
      .CR          (CR),
      .axiReq_i    (axiReq_i),
      .axiRsp_o    (axiRsp_o),
      .layerRegs_o (layerRegs),
      .ctrl_o      (ctrl)
   );

   pixelTiming timing
   (
      .clk        (clk),
      .CR         (CR),
      .pixelEn_o  (pixelEn),
      .tileLoad_o (tileLoad)
   );

   // one shifter per layer
   genvar k;
   generate
      for (k = 0; k < `SV_LAYERS; k++)
      begin : gLayer
         planeShifter shifter
         (
            .clk         (clk),
            .CR          (CR),
            .pixelEn_i   (pixelEn),
            .tileLoad_i  (tileLoad),
            .layerRegs_i (layerRegs[k]),
            .flip_i      (ctrl.flip),
            .pixel_o     (layerPixels[k])
         );
      end
   endgenerate

   layerMixer mixer
   (
      .clk           (clk),
      .CR            (CR),
      .pixelEn_i     (pixelEn),
      .tileLoad_i    (tileLoad),
      .layerEnable_i (ctrl.layerEnable),
      .layerPixels_i (layerPixels),
      .pixel_o       (pixel_o),
      .pixelValid_o  (pixelValid_o),
      .tileStart_o   (tileStart_o)
   );

endmodule

`default_nettype wire

//--- source/layerMixer.sv
// front layer selection and registered palette index output, one pixel per strobe
`default_nettype none

`include "starforceVideo_defines.svh"

module layerMixer
(
   input  wire                                        clk,
   input  wire                                        CR,
   input  wire                                        pixelEn_i,
   input  wire                                        tileLoad_i,
   input  wire  [`SV_LAYERS-1:0]                      layerEnable_i,
   input  wire  starforcePkg::layerPixel_t [`SV_LAYERS-1:0] layerPixels_i,
   output starforcePkg::videoPixel_t                  pixel_o,
   output logic                                       pixelValid_o,
   output logic                                       tileStart_o
);

   logic [`SV_LAYERS-1:0]     enableQ;
   logic                      startPending;
   starforcePkg::videoPixel_t selPixel;

   // ==================================================
   // priority select, lowest layer wins
   // ==================================================

   always_comb
   begin
      selPixel.colorIndex = '0;
      selPixel.layerId    = 2'(`SV_LAYERS);
      // walk from the back so the front layer overrides
      for (int k = `SV_LAYERS - 1; k >= 0; k--)
      begin
         if (enableQ[k] && (layerPixels_i[k].value != '0))
         begin
            selPixel.colorIndex = {layerPixels_i[k].bank, layerPixels_i[k].value};
            selPixel.layerId    = 2'(k);
         end
      end
   end

   // enables latched with the tile, like the planes
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         enableQ      <= '0;
         startPending <= 1'b0;
         pixelValid_o <= 1'b0;
         tileStart_o  <= 1'b0;
      end
      else
      begin
         if (tileLoad_i)
            enableQ <= layerEnable_i;
         if (tileLoad_i)
            startPending <= 1'b1;
         else if (pixelEn_i)
            startPending <= 1'b0;
         pixelValid_o <= pixelEn_i;
         tileStart_o  <= pixelEn_i & startPending;
      end
   end

   always_ff @(posedge clk)
   begin
      if (pixelEn_i)
         pixel_o <= selPixel;
   end

endmodule

`default_nettype wire

//--- source/planeShifter.sv
// one layer's bitplane shift registers with parallel load and flip-controlled direction
`default_nettype none

`include "starforceVideo_defines.svh"

module planeShifter
(
   input  wire                             clk,
   input  wire                             CR,
   input  wire                             pixelEn_i,
   input  wire                             tileLoad_i,
   input  wire  starforcePkg::layerRegs_t  layerRegs_i,
   input  wire                             flip_i,
   output starforcePkg::layerPixel_t       pixel_o
);

   logic [`SV_PLANES-1:0][`SV_TILE_W-1:0] planeQ;
   logic [`SV_BANK_W-1:0]                 bankQ;
   logic                                  flipQ;

   // ==================================================
   // shift registers
   // ==================================================

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         planeQ <= '0;
         bankQ  <= '0;
         flipQ  <= 1'b0;
      end
      else if (tileLoad_i)
      begin
         // parallel load, direction fixed for the whole tile
         planeQ <= layerRegs_i.planes;
         bankQ  <= layerRegs_i.bank;
         flipQ  <= flip_i;
      end
      else if (pixelEn_i)
      begin
         for (int p = 0; p < `SV_PLANES; p++)
         begin
            if (flipQ)
               planeQ[p] <= {1'b0, planeQ[p][`SV_TILE_W-1:1]};
            else
               planeQ[p] <= {planeQ[p][`SV_TILE_W-2:0], 1'b0};
         end
      end
   end

   // presented pixel from the register heads
   always_comb
   begin
      for (int p = 0; p < `SV_PLANES; p++)
      begin
         if (flipQ)
            pixel_o.value[p] = planeQ[p][0];
         else
            pixel_o.value[p] = planeQ[p][`SV_TILE_W-1];
      end
      pixel_o.bank = bankQ;
   end

endmodule

`default_nettype wire

//--- source/pixelTiming.sv
// pixel strobe divider and tile pixel counter, drives the shifters and the mixer
`default_nettype none

`include "starforceVideo_defines.svh"

module pixelTiming
(
   input  wire  clk,
   input  wire  CR,
   output logic pixelEn_o,
   output logic tileLoad_o
);

   localparam int DivW = $clog2(`SV_PIXEL_DIV);
   localparam int PixW = $clog2(`SV_TILE_W);

   logic [DivW-1:0] divCnt;
   logic [PixW-1:0] pixCnt;
   logic            strobe;
   logic            tileWrap;

   // one strobe per SV_PIXEL_DIV clocks
   assign strobe   = (divCnt == DivW'(`SV_PIXEL_DIV - 1));
   assign tileWrap = (pixCnt == PixW'(`SV_TILE_W - 1));

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         divCnt <= '0;
         pixCnt <= '0;
      end
      else
      begin
         if (strobe)
         begin
            divCnt <= '0;
            // tile counter wraps 7 to 0
            pixCnt <= pixCnt + 1'b1;
         end
         else
            divCnt <= divCnt + 1'b1;
      end
   end

   assign pixelEn_o  = strobe;
   assign tileLoad_o = strobe & tileWrap;

endmodule

`default_nettype wire

//--- source/axiLiteRegs.sv
// AXI4-Lite slave holding the per-layer plane and bank registers and the control register
`default_nettype none

`include "starforceVideo_defines.svh"

module axiLiteRegs
(
   input  wire                                    clk,
   input  wire                                    CR,
   input  wire  starforcePkg::axiLiteReq_t        axiReq_i,
   output starforcePkg::axiLiteRsp_t              axiRsp_o,
   output starforcePkg::layerRegs_t [`SV_LAYERS-1:0] layerRegs_o,
   output starforcePkg::ctrlRegs_t                ctrl_o
);

   starforcePkg::layerRegs_t [`SV_LAYERS-1:0] layerRegs;
   starforcePkg::ctrlRegs_t                   ctrl;

   logic                  wrAccept;
   logic                  rdAccept;
   logic [`SV_LAYERS-1:0] wrPlaneSel;
   logic [`SV_LAYERS-1:0] wrBankSel;
   logic                  wrCtrlSel;
   logic                  wrHit;
   logic                  rdHit;
   logic [31:0]           rdValue;

   logic                  bvalid;
   logic                  rvalid;
   starforcePkg::axiResp_t bresp;
   starforcePkg::axiResp_t rresp;
   logic [31:0]           rdata;

   function automatic starforcePkg::axiAddr_t planeAddr(input int k);
      return starforcePkg::axiAddr_t'(k * `SV_LAYER_STRIDE + `SV_PLANES_OFS);
   endfunction

   function automatic starforcePkg::axiAddr_t bankAddr(input int k);
      return starforcePkg::axiAddr_t'(k * `SV_LAYER_STRIDE + `SV_BANK_OFS);
   endfunction

   // write needs AW and W together, one response outstanding at most
   assign wrAccept = axiReq_i.awvalid & axiReq_i.wvalid & ~bvalid;
   assign rdAccept = axiReq_i.arvalid & ~rvalid;

   // ==================================================
   // address decode
   // ==================================================

   always_comb
   begin
      wrPlaneSel = '0;
      wrBankSel  = '0;
      for (int k = 0; k < `SV_LAYERS; k++)
      begin
         wrPlaneSel[k] = (axiReq_i.awaddr == planeAddr(k));
         wrBankSel[k]  = (axiReq_i.awaddr == bankAddr(k));
      end
      wrCtrlSel = (axiReq_i.awaddr == `SV_CTRL_ADDR);
      wrHit     = (|wrPlaneSel) | (|wrBankSel) | wrCtrlSel;
   end

   // read mux, zero-extended fields
   always_comb
   begin
      rdHit   = 1'b0;
      rdValue = '0;
      for (int k = 0; k < `SV_LAYERS; k++)
      begin
         if (axiReq_i.araddr == planeAddr(k))
         begin
            rdHit = 1'b1;
            rdValue[`SV_PLANES*`SV_TILE_W-1:0] = layerRegs[k].planes;
         end
         if (axiReq_i.araddr == bankAddr(k))
         begin
            rdHit = 1'b1;
            rdValue[`SV_BANK_W-1:0] = layerRegs[k].bank;
         end
      end
      if (axiReq_i.araddr == `SV_CTRL_ADDR)
      begin
         rdHit = 1'b1;
         rdValue[`SV_LAYERS-1:0] = ctrl.layerEnable;
         rdValue[8] = ctrl.flip;
      end
   end

   // ==================================================
   // register file and handshakes
   // ==================================================

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         layerRegs <= '0;
         ctrl      <= '0;
         bvalid    <= 1'b0;
         rvalid    <= 1'b0;
      end
      else
      begin
         if (wrAccept)
         begin
            bvalid <= 1'b1;
            for (int k = 0; k < `SV_LAYERS; k++)
            begin
               // byte lanes follow wstrb
               for (int p = 0; p < `SV_PLANES; p++)
               begin
                  if (wrPlaneSel[k] && axiReq_i.wstrb[p])
                     layerRegs[k].planes[p] <= axiReq_i.wdata[p*8 +: 8];
               end
               if (wrBankSel[k] && axiReq_i.wstrb[0])
                  layerRegs[k].bank <= axiReq_i.wdata[`SV_BANK_W-1:0];
            end
            if (wrCtrlSel && axiReq_i.wstrb[0])
               ctrl.layerEnable <= axiReq_i.wdata[`SV_LAYERS-1:0];
            if (wrCtrlSel && axiReq_i.wstrb[1])
               ctrl.flip <= axiReq_i.wdata[8];
         end
         else if (bvalid && axiReq_i.bready)
            bvalid <= 1'b0;

         if (rdAccept)
            rvalid <= 1'b1;
         else if (rvalid && axiReq_i.rready)
            rvalid <= 1'b0;
      end
   end

   // response payloads, held until taken
   always_ff @(posedge clk)
   begin
      if (wrAccept)
         bresp <= wrHit ? starforcePkg::RESP_OKAY : starforcePkg::RESP_SLVERR;
      if (rdAccept)
      begin
         rdata <= rdValue;
         rresp <= rdHit ? starforcePkg::RESP_OKAY : starforcePkg::RESP_SLVERR;
      end
   end

   assign axiRsp_o.awready = wrAccept;
   assign axiRsp_o.wready  = wrAccept;
   assign axiRsp_o.bresp   = bresp;
   assign axiRsp_o.bvalid  = bvalid;
   assign axiRsp_o.arready = rdAccept;
   assign axiRsp_o.rdata   = rdata;
   assign axiRsp_o.rresp   = rresp;
   assign axiRsp_o.rvalid  = rvalid;

   assign layerRegs_o = layerRegs;
   assign ctrl_o      = ctrl;

endmodule

`default_nettype wire

//--- source/starforcePkg.sv
// shared struct types for the tile video engine, referenced by scoped name from RTL and testbench
`default_nettype none

`include "starforceVideo_defines.svh"

package starforcePkg;

   // ==================================================
   // bus side
   // ==================================================

   typedef logic [`SV_ADDR_W-1:0] axiAddr_t;

   typedef enum logic [1:0]
   {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axiResp_t;

   // master to slave, all five channels
   typedef struct packed
   {
      axiAddr_t    awaddr;
      logic        awvalid;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
      logic        wvalid;
      logic        bready;
      axiAddr_t    araddr;
      logic        arvalid;
      logic        rready;
   } axiLiteReq_t;

   // slave to master
   typedef struct packed
   {
      logic        awready;
      logic        wready;
      axiResp_t    bresp;
      logic        bvalid;
      logic        arready;
      logic [31:0] rdata;
      axiResp_t    rresp;
      logic        rvalid;
   } axiLiteRsp_t;

   // ==================================================
   // video side
   // ==================================================

   // plane 0 sits in the lowest byte
   typedef struct packed
   {
      logic [`SV_BANK_W-1:0]                   bank;
      logic [`SV_PLANES-1:0][`SV_TILE_W-1:0]   planes;
   } layerRegs_t;

   typedef struct packed
   {
      logic                  flip;
      logic [`SV_LAYERS-1:0] layerEnable;
   } ctrlRegs_t;

   // value msb comes from plane 2
   typedef struct packed
   {
      logic [`SV_BANK_W-1:0] bank;
      logic [`SV_PLANES-1:0] value;
   } layerPixel_t;

   // layerId equal to SV_LAYERS marks background
   typedef struct packed
   {
      logic [`SV_BANK_W+`SV_PLANES-1:0] colorIndex;
      logic [1:0]                       layerId;
   } videoPixel_t;

endpackage

`default_nettype wire

//--- source/starforceVideo_defines.svh
// sizing and register map macros for the tile video engine, include wherever a block needs them
`ifndef STARFORCEVIDEO_DEFINES_SVH
`define STARFORCEVIDEO_DEFINES_SVH

// ==================================================
// layer geometry
// ==================================================

// tile layers, layer 0 is the front one
`define SV_LAYERS 3

// bitplanes per layer
`define SV_PLANES 3

// pixels per tile, also bits per plane byte
`define SV_TILE_W 8

// clk cycles per pixel strobe
`define SV_PIXEL_DIV 4

// colour bank bits above the pixel value
`define SV_BANK_W 4

// ==================================================
// register map
// ==================================================

`define SV_ADDR_W 8
`define SV_CTRL_ADDR 8'h30
`define SV_LAYER_STRIDE 8'h10

// offsets inside one layer's window
`define SV_PLANES_OFS 8'h0
`define SV_BANK_OFS 8'h4

`endif
